/* hw/mul_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiplier widths, mode enum, operand struct
// and the per-level row count table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mul_pkg;

    localparam int XLEN = 32;
    localparam int PLEN = 2 * XLEN;

    // registered 3:2 levels between the row generator and the final adder
    localparam int NUM_STAGES = 8;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [PLEN-1:0] prod_t;

    typedef enum logic {
        MODE_UNSIGNED = 1'b0,
        MODE_SIGNED   = 1'b1
    } mul_mode_e;

    // magnitudes plus the sign of the final product
    typedef struct packed {
        word_t a_mag;
        word_t b_mag;
        logic  neg;
    } operands_t;

    // every full group of three rows becomes two, leftovers pass through
    function automatic int rows_after(input int n);
        return (n / 3) * 2 + (n % 3);
    endfunction

    function automatic int rows_at_level(input int level);
        int n;
        n = XLEN;
        for (int i = 0; i < level; i++)
        begin
            n = rows_after(n);
        end
        return n;
    endfunction

    // rows entering each level, last entry is what leaves level 7
    // 32 22 15 10 7 5 4 3 2
    localparam int ROW_COUNT [0:NUM_STAGES] = '{
        rows_at_level(0),
        rows_at_level(1),
        rows_at_level(2),
        rows_at_level(3),
        rows_at_level(4),
        rows_at_level(5),
        rows_at_level(6),
        rows_at_level(7),
        rows_at_level(8)
    };

endpackage

`default_nettype wire

/* hw/operand_conditioner.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand_conditioner: magnitudes and product sign
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module operand_conditioner (
    input  mul_pkg::word_t     a,
    input  mul_pkg::word_t     b,
    input  mul_pkg::mul_mode_e mode,
    output mul_pkg::operands_t ops
);
    import mul_pkg::*;

    logic a_neg;
    logic b_neg;

    // only signed mode looks at the top bits
    assign a_neg = (mode == MODE_SIGNED) && a[XLEN-1];
    assign b_neg = (mode == MODE_SIGNED) && b[XLEN-1];

    // two's complement of the most negative value is 2^31, still fits unsigned
    assign ops.a_mag = a_neg ? -a : a;
    assign ops.b_mag = b_neg ? -b : b;
    assign ops.neg   = a_neg ^ b_neg;

    always_comb
    begin
        assert (mode == MODE_SIGNED || !ops.neg)
        else
            $error("operand_conditioner: neg set in unsigned mode");
    end

endmodule

`default_nettype wire

/* hw/partial_product_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// partial_product_gen: shifted and-gated rows
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module partial_product_gen (
    input  mul_pkg::operands_t              ops,
    output mul_pkg::prod_t [mul_pkg::XLEN-1:0] rows,
    output logic                            neg
);
    import mul_pkg::*;

    prod_t a_wide;

    // zero extend the a magnitude to product width once
    assign a_wide = {{(PLEN-XLEN){1'b0}}, ops.a_mag};

    for (genvar j = 0; j < XLEN; j++)
    begin : g_row
        // row j carries weight 2^j when bit j of b is set
        assign rows[j] = ops.b_mag[j] ? (a_wide << j) : '0;
    end

    assign neg = ops.neg;

endmodule

`default_nettype wire

/* hw/csa_reduce_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csa_reduce_stage: one registered 3:2 level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module csa_reduce_stage #(
    parameter int ROWS_IN = 3
) (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  mul_pkg::prod_t [ROWS_IN-1:0]                       rows_in,
    input  logic                                               neg_in,
    output mul_pkg::prod_t [mul_pkg::rows_after(ROWS_IN)-1:0]  rows_out,
    output logic                                               neg_out
);
    import mul_pkg::*;

    localparam int ROWS_OUT = rows_after(ROWS_IN);
    localparam int GROUPS   = ROWS_IN / 3;
    localparam int LEFT     = ROWS_IN % 3;

    prod_t [ROWS_OUT-1:0] nxt_rows;

    for (genvar g = 0; g < GROUPS; g++)
    begin : g_csa
        prod_t x;
        prod_t y;
        prod_t z;

        assign x = rows_in[3*g];
        assign y = rows_in[3*g+1];
        assign z = rows_in[3*g+2];

        // bitwise full adders, carry row moves up one weight
        // the carry out of bit 63 is beyond the product and is dropped
        assign nxt_rows[2*g]   = x ^ y ^ z;
        assign nxt_rows[2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
    end

    // one or two rows that do not fill a group go through untouched
    for (genvar k = 0; k < LEFT; k++)
    begin : g_pass
        assign nxt_rows[2*GROUPS+k] = rows_in[3*GROUPS+k];
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rows_out <= '0;
            neg_out  <= 1'b0;
        end
        else
        begin
            rows_out <= nxt_rows;
            neg_out  <= neg_in;
        end
    end

    // running totals of both sides of the register
    prod_t in_sum;
    prod_t out_sum;

    always_comb
    begin
        in_sum = '0;
        for (int i = 0; i < ROWS_IN; i++)
        begin
            in_sum = in_sum + rows_in[i];
        end
    end

    always_comb
    begin
        out_sum = '0;
        for (int i = 0; i < ROWS_OUT; i++)
        begin
            out_sum = out_sum + rows_out[i];
        end
    end

    // compression keeps the value of the rows, mod 2^64, across the clock
    a_sum_kept: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (out_sum == $past(in_sum))
    )
    else
        $error("csa_reduce_stage %0d: row sum changed", ROWS_IN);

endmodule

`default_nettype wire

/* hw/product_adder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// product_adder: final add and sign restore
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module product_adder (
    input  mul_pkg::prod_t [1:0] rows,
    input  logic                 neg,
    output mul_pkg::word_t       hi,
    output mul_pkg::word_t       lo
);
    import mul_pkg::*;

    prod_t mag;
    prod_t result;

    // carry-propagate add of the last sum and carry rows
    assign mag = rows[0] + rows[1];

    // negate all 64 bits so the +1 ripples from lo into hi
    assign result = neg ? -mag : mag;

    assign hi = result[PLEN-1:XLEN];
    assign lo = result[XLEN-1:0];

endmodule

`default_nettype wire

/* hw/mul32_pipe.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mul32_pipe: pipelined 32x32 multiplier top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module mul32_pipe (
    input  logic               clk,
    input  logic               rst_n,
    input  mul_pkg::word_t     a,
    input  mul_pkg::word_t     b,
    input  mul_pkg::mul_mode_e mode,
    output mul_pkg::word_t     hi,
    output mul_pkg::word_t     lo
);
    import mul_pkg::*;

    operands_t ops;

    // rows at each level boundary, only the low ROW_COUNT[s] entries are live
    prod_t [XLEN-1:0] stage_rows [0:NUM_STAGES];
    logic  [NUM_STAGES:0] stage_neg;

    operand_conditioner u_cond (
        .a    (a),
        .b    (b),
        .mode (mode),
        .ops  (ops)
    );

    partial_product_gen u_ppg (
        .ops  (ops),
        .rows (stage_rows[0]),
        .neg  (stage_neg[0])
    );

    // neg rides in the same registers as its rows
    for (genvar s = 0; s < NUM_STAGES; s++)
    begin : g_level
        csa_reduce_stage #(
            .ROWS_IN (ROW_COUNT[s])
        ) u_csa (
            .clk      (clk),
            .rst_n    (rst_n),
            .rows_in  (stage_rows[s][ROW_COUNT[s]-1:0]),
            .neg_in   (stage_neg[s]),
            .rows_out (stage_rows[s+1][ROW_COUNT[s+1]-1:0]),
            .neg_out  (stage_neg[s+1])
        );

        if (ROW_COUNT[s+1] < XLEN)
        begin : g_tie
            assign stage_rows[s+1][XLEN-1:ROW_COUNT[s+1]] = '0;
        end
    end

    product_adder u_add (
        .rows (stage_rows[NUM_STAGES][1:0]),
        .neg  (stage_neg[NUM_STAGES]),
        .hi   (hi),
        .lo   (lo)
    );

endmodule

`default_nettype wire

/* test/tb_vectors.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed operand pairs with expected products
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

    // columns: name, a, b, mode, expected 64-bit product as hi_lo
    // modes alternate entry by entry so neg has to follow its own data
    task automatic load_vectors();
        add_vector("u_zero", 32'h0000_0000, 32'h0000_0000, MODE_UNSIGNED,
                   64'h0000_0000_0000_0000);
        add_vector("s_zero_neg", 32'h0000_0000, 32'hFFFF_FFFF, MODE_SIGNED,
                   64'h0000_0000_0000_0000);
        add_vector("u_one", 32'h0000_0001, 32'h0000_0001, MODE_UNSIGNED,
                   64'h0000_0000_0000_0001);
        add_vector("s_pos_pos", 32'h0000_0007, 32'h0000_0006, MODE_SIGNED,
                   64'h0000_0000_0000_002A);
        add_vector("u_ones_ones", 32'hFFFF_FFFF, 32'hFFFF_FFFF, MODE_UNSIGNED,
                   64'hFFFF_FFFE_0000_0001);
        add_vector("s_neg_neg", 32'hFFFF_FFFF, 32'hFFFF_FFFF, MODE_SIGNED,
                   64'h0000_0000_0000_0001);
        add_vector("u_one_ones", 32'h0000_0001, 32'hFFFF_FFFF, MODE_UNSIGNED,
                   64'h0000_0000_FFFF_FFFF);
        add_vector("s_pos_neg", 32'h0000_0003, 32'hFFFF_FFFB, MODE_SIGNED,
                   64'hFFFF_FFFF_FFFF_FFF1);
        add_vector("u_min_two", 32'h8000_0000, 32'h0000_0002, MODE_UNSIGNED,
                   64'h0000_0001_0000_0000);
        add_vector("s_neg_pos", 32'hFFFF_FFF9, 32'h0000_0006, MODE_SIGNED,
                   64'hFFFF_FFFF_FFFF_FFD6);
        add_vector("u_half_half", 32'h0000_FFFF, 32'h0000_FFFF, MODE_UNSIGNED,
                   64'h0000_0000_FFFE_0001);
        add_vector("s_neg_neg_small", 32'hFFFF_FFF8, 32'hFFFF_FFF7, MODE_SIGNED,
                   64'h0000_0000_0000_0048);
        add_vector("u_shift", 32'h1234_5678, 32'h0000_0010, MODE_UNSIGNED,
                   64'h0000_0001_2345_6780);
        add_vector("s_min_min", 32'h8000_0000, 32'h8000_0000, MODE_SIGNED,
                   64'h4000_0000_0000_0000);
        add_vector("u_ones_min", 32'hFFFF_FFFF, 32'h8000_0000, MODE_UNSIGNED,
                   64'h7FFF_FFFF_8000_0000);
        add_vector("s_min_neg1", 32'h8000_0000, 32'hFFFF_FFFF, MODE_SIGNED,
                   64'h0000_0000_8000_0000);
        add_vector("u_min_min", 32'h8000_0000, 32'h8000_0000, MODE_UNSIGNED,
                   64'h4000_0000_0000_0000);
        add_vector("s_min_one", 32'h8000_0000, 32'h0000_0001, MODE_SIGNED,
                   64'hFFFF_FFFF_8000_0000);
        add_vector("u_three_fives", 32'h0000_0003, 32'h5555_5555, MODE_UNSIGNED,
                   64'h0000_0000_FFFF_FFFF);
        add_vector("s_max_max", 32'h7FFF_FFFF, 32'h7FFF_FFFF, MODE_SIGNED,
                   64'h3FFF_FFFF_0000_0001);
        add_vector("u_times_zero", 32'hDEAD_BEEF, 32'h0000_0000, MODE_UNSIGNED,
                   64'h0000_0000_0000_0000);
        add_vector("s_max_min", 32'h7FFF_FFFF, 32'h8000_0000, MODE_SIGNED,
                   64'hC000_0000_8000_0000);
        add_vector("u_max_max", 32'h7FFF_FFFF, 32'h7FFF_FFFF, MODE_UNSIGNED,
                   64'h3FFF_FFFF_0000_0001);
        add_vector("s_neg1_max", 32'hFFFF_FFFF, 32'h7FFF_FFFF, MODE_SIGNED,
                   64'hFFFF_FFFF_8000_0001);
    endtask

`endif

/* test/tb_mul32_pipe.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the pipelined multiplier
// directed table, random pairs, latency check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_mul32_pipe;
    import mul_pkg::*;

    localparam int NUM_RANDOM  = 400;
    localparam int DRAIN_LIMIT = 4 * NUM_STAGES;

    typedef struct packed {
        word_t     a;
        word_t     b;
        mul_mode_e mode;
        prod_t     expected;
    } vector_t;

    logic      clk;
    logic      rst_n;
    word_t     a;
    word_t     b;
    mul_mode_e mode;
    word_t     hi;
    word_t     lo;

    vector_t vec_q[$];
    string   vec_name[$];

    // products in flight and the cycle each one is due
    prod_t   want_q[$];
    int      due_q[$];
    string   name_q[$];

    int      cyc;
    int      checks;
    int      errors;
    int      products_seen;
    integer  seed;

    mul32_pipe u_mul32_pipe (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (a),
        .b     (b),
        .mode  (mode),
        .hi    (hi),
        .lo    (lo)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // extend both operands to 64 bits and keep the low 64 bits of the product
    function automatic prod_t ref_product(input word_t x, input word_t y, input mul_mode_e m);
        prod_t wx;
        prod_t wy;
        if (m == MODE_SIGNED)
        begin
            wx = {{XLEN{x[XLEN-1]}}, x};
            wy = {{XLEN{y[XLEN-1]}}, y};
        end
        else
        begin
            wx = {{XLEN{1'b0}}, x};
            wy = {{XLEN{1'b0}}, y};
        end
        return wx * wy;
    endfunction

    task automatic add_vector(input string name, input word_t va, input word_t vb,
                              input mul_mode_e vm, input prod_t vexp);
        vector_t v;
        v.a        = va;
        v.b        = vb;
        v.mode     = vm;
        v.expected = vexp;
        vec_q.push_back(v);
        vec_name.push_back(name);
    endtask

    `include "tb_vectors.svh"

    // called on a falling edge when hi and lo have settled since the rising edge
    task automatic check_output();
        prod_t want;
        string name;
        if (due_q.size() > 0 && due_q[0] == cyc)
        begin
            want = want_q.pop_front();
            name = name_q.pop_front();
            due_q.delete(0);
            checks++;
            products_seen++;
            if ({hi, lo} !== want)
            begin
                errors++;
                $display("ERR %s expected %h:%h actual %h:%h",
                         name, want[PLEN-1:XLEN], want[XLEN-1:0], hi, lo);
            end
        end
        else if (products_seen == 0)
        begin
            // nothing has reached the adder yet so the registers still hold reset zeros
            checks++;
            if (hi !== '0 || lo !== '0)
            begin
                errors++;
                $display("ERR after_reset expected %h:%h actual %h:%h",
                         32'h0, 32'h0, hi, lo);
            end
        end
    endtask

    task automatic apply_pair(input string name, input word_t va, input word_t vb,
                              input mul_mode_e vm, input prod_t want);
        check_output();
        a    = va;
        b    = vb;
        mode = vm;
        want_q.push_back(want);
        due_q.push_back(cyc + NUM_STAGES);
        name_q.push_back(name);
        @(negedge clk);
        cyc++;
    endtask

    initial
    begin
        vector_t   v;
        word_t     ra;
        word_t     rb;
        mul_mode_e rm;
        integer    r;
        int        drain;

        // busy operands during reset so only the reset can zero the pipeline
        rst_n         = 1'b0;
        a             = 32'hFFFF_FFFF;
        b             = 32'hFFFF_FFFF;
        mode          = MODE_UNSIGNED;
        cyc           = 0;
        checks        = 0;
        errors        = 0;
        products_seen = 0;
        seed          = 32'h5099_3438;
        load_vectors();

        // four rising edges with reset low
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // one entry per cycle with no gaps
        foreach (vec_q[i])
        begin
            v = vec_q[i];
            if (ref_product(v.a, v.b, v.mode) !== v.expected)
            begin
                errors++;
                $display("table entry %s does not match the reference arithmetic",
                         vec_name[i]);
            end
            apply_pair(vec_name[i], v.a, v.b, v.mode, v.expected);
        end

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            ra = $random(seed);
            rb = $random(seed);
            r  = $random(seed);
            rm = mul_mode_e'(r[0]);
            apply_pair($sformatf("random_%0d", i), ra, rb, rm, ref_product(ra, rb, rm));
        end

        a    = '0;
        b    = '0;
        mode = MODE_UNSIGNED;
        drain = 0;
        while (due_q.size() > 0 && drain < DRAIN_LIMIT)
        begin
            check_output();
            @(negedge clk);
            cyc++;
            drain++;
        end
        if (due_q.size() > 0)
        begin
            errors++;
            $display("timeout: %0d products never reached the output", due_q.size());
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mul32_pipe.f */
+incdir+test
hw/mul_pkg.sv
hw/operand_conditioner.sv
hw/partial_product_gen.sv
hw/csa_reduce_stage.sv
hw/product_adder.sv
hw/mul32_pipe.sv
test/tb_mul32_pipe.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mul32_pipe testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mul32_pipe \
    -f mul32_pipe.f

sim_status=0
sim_out=$(./obj_dir/Vtb_mul32_pipe) || sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]
then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST PASSED" <<< "$sim_out"
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
